//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = dcache_tb
FILELIST   = src.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST PASS" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src.f
src/dcache_pkg.sv
src/dcache_ctrl.sv
src/dcache_array.sv
src/dcache_miss_unit.sv
src/dcache_top.sv
verification/dcache_tb.sv

//--- src/dcache_array.sv
/*
 * dcache array
 * two-way tag, state and line storage with a registered read index,
 * late tag compare, victim choice and byte-masked writes
 */
`timescale 1ns/1ns

module dcache_array (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  dcache_pkg::array_req_t ctrl_req_i,
    input  dcache_pkg::array_req_t refill_req_i,
    output dcache_pkg::array_rsp_t rsp_o
);

    localparam int unsigned WAYS  = dcache_pkg::DCACHE_NUM_WAYS;
    localparam int unsigned SETS  = dcache_pkg::DCACHE_NUM_SETS;
    localparam int unsigned OFS   = dcache_pkg::DCACHE_BYTE_OFFSET;
    localparam int unsigned SET_W = dcache_pkg::DCACHE_SET_WIDTH;
    localparam int unsigned BYTES = dcache_pkg::DCACHE_LINE_WIDTH / 8;
    localparam int unsigned WAY_W = $clog2(WAYS);

    logic [dcache_pkg::DCACHE_TAG_WIDTH-1:0]  tag_q  [WAYS][SETS];
    logic [dcache_pkg::DCACHE_LINE_WIDTH-1:0] data_q [WAYS][SETS];
    logic [WAYS-1:0]                          valid_q [SETS];
    logic [WAYS-1:0]                          dirty_q [SETS];
    logic [WAY_W-1:0]                         rr_q    [SETS];
    logic [SET_W-1:0]                         idx_q;
    logic [SET_W-1:0]                         set_sel;
    logic [WAY_W-1:0]                         victim;
    dcache_pkg::array_req_t                   req;

    // refill port has priority
    assign req     = (|refill_req_i.way_req) ? refill_req_i : ctrl_req_i;
    assign set_sel = req.index[OFS +: SET_W];

    // ------------------------------
    // read side
    // ------------------------------
    always_comb begin
        // invalid way first, lowest index wins; else round robin
        victim = rr_q[idx_q];
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid_q[idx_q][w]) begin
                victim = WAY_W'(w);
            end
        end
        rsp_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            rsp_o.hit_way[w] = valid_q[idx_q][w] && (tag_q[w][idx_q] == ctrl_req_i.tag);
            if (rsp_o.hit_way[w]) begin
                rsp_o.rdata = data_q[w][idx_q];
            end
        end
        rsp_o.victim_way   = dcache_pkg::way_mask_t'(1) << victim;
        rsp_o.victim_line  = data_q[victim][idx_q];
        rsp_o.victim_tag   = tag_q[victim][idx_q];
        rsp_o.victim_dirty = dirty_q[idx_q][victim];
        rsp_o.victim_valid = valid_q[idx_q][victim];
    end

    // ------------------------------
    // storage
    // ------------------------------
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < WAYS; w++) begin
            if (req.we && req.way_req[w]) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (req.be[b]) begin
                        data_q[w][set_sel][b*8 +: 8] <= req.wdata[b*8 +: 8];
                    end
                end
                // tag only changes with a refill
                if (req.set_valid) begin
                    tag_q[w][set_sel] <= req.tag;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            idx_q <= '0;
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else begin
            // index only moves on a lookup
            if (|req.way_req && !req.we) begin
                idx_q <= set_sel;
            end
            if (req.we) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (req.way_req[w]) begin
                        dirty_q[set_sel][w] <= req.set_dirty;
                        if (req.set_valid) begin
                            valid_q[set_sel][w] <= 1'b1;
                        end
                    end
                end
                if (req.set_valid) begin
                    rr_q[set_sel] <= rr_q[set_sel] + 1'b1;
                end
            end
        end
    end

    // refills never leave a tag in two ways of one set
    hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(rsp_o.hit_way))
        else $error("more than one way hit");

endmodule

//--- src/dcache_ctrl.sv
/*
 * dcache controller
 * FSM for lookup, store write pass and load hit chaining; misses and
 * uncacheable accesses are handed to the miss unit
 */
`timescale 1ns/1ns

module dcache_ctrl #(
    parameter logic [dcache_pkg::DCACHE_ADDR_WIDTH-1:0] CACHEABLE_BASE = 32'h0000_1000
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  dcache_pkg::dcache_req_t req_i,
    output dcache_pkg::dcache_rsp_t rsp_o,
    output dcache_pkg::array_req_t array_req_o,
    input  dcache_pkg::array_rsp_t array_rsp_i,
    output dcache_pkg::miss_req_t  miss_req_o,
    input  dcache_pkg::miss_rsp_t  miss_rsp_i,
    output logic                   busy_o
);

    localparam int unsigned WORD = dcache_pkg::DCACHE_WORD_WIDTH;
    localparam int unsigned LINE = dcache_pkg::DCACHE_LINE_WIDTH;
    localparam int unsigned OFS  = dcache_pkg::DCACHE_BYTE_OFFSET;
    localparam int unsigned WOFS = dcache_pkg::DCACHE_WORD_OFFSET;

    // WAIT_TAG_BYPASSED holds an uncacheable access at the miss unit
    // WAIT_MISS holds a cacheable one
    typedef enum logic [2:0] {
        IDLE,
        WAIT_TAG,
        WAIT_TAG_BYPASSED,
        STORE_REQ,
        WAIT_MISS,
        WAIT_CRITICAL_WORD
    } state_e;

    state_e                                  state_q, state_d;
    dcache_pkg::dcache_req_t                 pend_q, pend_d;
    dcache_pkg::way_mask_t                   hit_way_q, hit_way_d;
    logic [WORD-1:0]                         crit_q, crit_d;
    logic [OFS-WOFS-1:0]                     word_sel;
    logic [dcache_pkg::DCACHE_ADDR_WIDTH-1:0] lookup_addr;
    logic                                    uncacheable;
    logic                                    accept;

    assign busy_o      = (state_q != IDLE);
    assign word_sel    = pend_q.address_index[OFS-1:WOFS];
    // late tag joined with the saved index
    assign lookup_addr = {req_i.address_tag, pend_q.address_index};
    assign uncacheable = (lookup_addr < CACHEABLE_BASE);

    // ------------------------------
    // cache FSM
    // ------------------------------
    always_comb begin
        state_d   = state_q;
        pend_d    = pend_q;
        hit_way_d = hit_way_q;
        crit_d    = crit_q;
        accept    = 1'b0;
        rsp_o     = '0;
        miss_req_o = '0;
        // array idle by default
        // tag always compared against the live tag
        array_req_o       = '0;
        array_req_o.index = req_i.address_index;
        array_req_o.tag   = req_i.address_tag;

        case (state_q)
            IDLE: begin
                accept = req_i.data_req;
            end

            WAIT_TAG: begin
                // array keeps the read index while the tag is late
                if (req_i.tag_valid) begin
                    pend_d.address_tag = req_i.address_tag;
                    if (uncacheable) begin
                        state_d = WAIT_TAG_BYPASSED;
                    end else if (|array_rsp_i.hit_way) begin
                        if (pend_q.data_we) begin
                            // second pass writes the word
                            state_d   = STORE_REQ;
                            hit_way_d = array_rsp_i.hit_way;
                        end else begin
                            rsp_o.data_rvalid = 1'b1;
                            rsp_o.data_rdata  = array_rsp_i.rdata[word_sel*WORD +: WORD];
                            state_d           = IDLE;
                            // chain the next access into this hit cycle
                            accept            = req_i.data_req;
                        end
                    end else begin
                        state_d = WAIT_MISS;
                    end
                end
            end

            STORE_REQ: begin
                array_req_o.way_req   = hit_way_q;
                array_req_o.we        = 1'b1;
                array_req_o.index     = pend_q.address_index;
                array_req_o.tag       = pend_q.address_tag;
                array_req_o.wdata     = {(LINE/WORD){pend_q.data_wdata}};
                array_req_o.be[word_sel*(WORD/8) +: WORD/8] = pend_q.data_be;
                array_req_o.set_dirty = 1'b1;
                rsp_o.data_gnt        = 1'b1;
                state_d               = IDLE;
            end

            WAIT_TAG_BYPASSED, WAIT_MISS: begin
                // held until the miss unit is done
                miss_req_o.valid  = 1'b1;
                miss_req_o.bypass = (state_q == WAIT_TAG_BYPASSED);
                miss_req_o.addr   = {pend_q.address_tag, pend_q.address_index};
                miss_req_o.we     = pend_q.data_we;
                miss_req_o.be     = pend_q.data_be;
                miss_req_o.wdata  = pend_q.data_wdata;
                if (miss_rsp_i.done) begin
                    if (pend_q.data_we) begin
                        rsp_o.data_gnt = 1'b1;
                        state_d        = IDLE;
                    end else begin
                        crit_d  = miss_rsp_i.rdata;
                        state_d = WAIT_CRITICAL_WORD;
                    end
                end
            end

            WAIT_CRITICAL_WORD: begin
                rsp_o.data_rvalid = 1'b1;
                rsp_o.data_rdata  = crit_q;
                state_d           = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // new access starts the lookup
        // loads are granted right away
        if (accept) begin
            pend_d              = req_i;
            array_req_o.way_req = '1;
            array_req_o.we      = 1'b0;
            array_req_o.index   = req_i.address_index;
            rsp_o.data_gnt      = !req_i.data_we;
            state_d             = WAIT_TAG;
        end
    end

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            hit_way_q <= '0;
        end else begin
            state_q   <= state_d;
            hit_way_q <= hit_way_d;
        end
    end

    always_ff @(posedge clk_i) begin
        pend_q <= pend_d;
        crit_q <= crit_d;
    end

    // a store is never granted while a load returns data
    store_gnt_no_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (rsp_o.data_gnt && req_i.data_we) |-> !rsp_o.data_rvalid)
        else $error("store grant together with rvalid");

endmodule

//--- src/dcache_miss_unit.sv
/*
 * dcache miss unit
 * dirty victim writeback and line refill for load misses; bypass
 * accesses and store misses as single-word memory accesses
 */
`timescale 1ns/1ns

module dcache_miss_unit (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  dcache_pkg::miss_req_t  miss_req_i,
    output dcache_pkg::miss_rsp_t  miss_rsp_o,
    input  dcache_pkg::array_rsp_t array_rsp_i,
    output dcache_pkg::array_req_t refill_req_o,
    output dcache_pkg::mem_req_t   mem_req_o,
    input  dcache_pkg::mem_rsp_t   mem_rsp_i
);

    localparam int unsigned ADDR  = dcache_pkg::DCACHE_ADDR_WIDTH;
    localparam int unsigned WORD  = dcache_pkg::DCACHE_WORD_WIDTH;
    localparam int unsigned LINE  = dcache_pkg::DCACHE_LINE_WIDTH;
    localparam int unsigned OFS   = dcache_pkg::DCACHE_BYTE_OFFSET;
    localparam int unsigned WOFS  = dcache_pkg::DCACHE_WORD_OFFSET;
    localparam int unsigned INDEX = dcache_pkg::DCACHE_INDEX_WIDTH;

    typedef enum logic [2:0] {
        M_IDLE,
        M_WRITEBACK,
        M_REFILL,
        M_SINGLE,
        M_DONE
    } mstate_e;

    mstate_e                                 state_q, state_d;
    logic [LINE-1:0]                         line_q, line_d;
    logic [dcache_pkg::DCACHE_TAG_WIDTH-1:0] vtag_q, vtag_d;
    dcache_pkg::way_mask_t                   vway_q, vway_d;
    logic [OFS-WOFS-1:0]                     word_sel;
    logic                                    fill;

    assign word_sel = miss_req_i.addr[OFS-1:WOFS];
    // only cacheable loads allocate
    assign fill     = !miss_req_i.bypass && !miss_req_i.we;

    always_comb begin
        state_d      = state_q;
        line_d       = line_q;
        vtag_d       = vtag_q;
        vway_d       = vway_q;
        mem_req_o    = '0;
        refill_req_o = '0;
        miss_rsp_o   = '0;

        case (state_q)
            M_IDLE: begin
                if (miss_req_i.valid) begin
                    if (fill) begin
                        // array still shows the looked-up set
                        line_d  = array_rsp_i.victim_line;
                        vtag_d  = array_rsp_i.victim_tag;
                        vway_d  = array_rsp_i.victim_way;
                        state_d = (array_rsp_i.victim_valid && array_rsp_i.victim_dirty) ?
                                  M_WRITEBACK : M_REFILL;
                    end else begin
                        state_d = M_SINGLE;
                    end
                end
            end

            M_WRITEBACK: begin
                mem_req_o.valid = 1'b1;
                mem_req_o.we    = 1'b1;
                mem_req_o.addr  = {vtag_q, miss_req_i.addr[INDEX-1:OFS], {OFS{1'b0}}};
                mem_req_o.be    = '1;
                mem_req_o.wdata = line_q;
                if (mem_rsp_i.ack) begin
                    state_d = M_REFILL;
                end
            end

            M_REFILL: begin
                mem_req_o.valid = 1'b1;
                mem_req_o.addr  = {miss_req_i.addr[ADDR-1:OFS], {OFS{1'b0}}};
                if (mem_rsp_i.ack) begin
                    line_d  = mem_rsp_i.rdata;
                    state_d = M_DONE;
                end
            end

            M_SINGLE: begin
                // word lands in the lane picked by the address
                mem_req_o.valid  = 1'b1;
                mem_req_o.we     = miss_req_i.we;
                mem_req_o.bypass = miss_req_i.bypass;
                mem_req_o.addr   = miss_req_i.addr;
                mem_req_o.be[word_sel*(WORD/8) +: WORD/8] = miss_req_i.be;
                mem_req_o.wdata  = {(LINE/WORD){miss_req_i.wdata}};
                if (mem_rsp_i.ack) begin
                    line_d  = mem_rsp_i.rdata;
                    state_d = M_DONE;
                end
            end

            M_DONE: begin
                miss_rsp_o.done  = 1'b1;
                miss_rsp_o.rdata = line_q[word_sel*WORD +: WORD];
                // install the line valid and clean
                if (fill) begin
                    refill_req_o.way_req   = vway_q;
                    refill_req_o.we        = 1'b1;
                    refill_req_o.index     = miss_req_i.addr[INDEX-1:0];
                    refill_req_o.tag       = miss_req_i.addr[ADDR-1:INDEX];
                    refill_req_o.wdata     = line_q;
                    refill_req_o.be        = '1;
                    refill_req_o.set_valid = 1'b1;
                end
                state_d = M_IDLE;
            end

            default: begin
                state_d = M_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= M_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        line_q <= line_d;
        vtag_q <= vtag_d;
        vway_q <= vway_d;
    end

    // memory request holds still until acked
    mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o.valid && !mem_rsp_i.ack) |=> $stable(mem_req_o))
        else $error("mem_req changed before ack");

endmodule

//--- src/dcache_pkg.sv
/*
 * dcache package
 * geometry of the two-way data cache and the packed structs that travel
 * between the core, the controller, the array, the miss unit and memory
 */
package dcache_pkg;

    // ------------------------------
    // geometry
    // ------------------------------
    localparam int unsigned DCACHE_ADDR_WIDTH  = 32;
    localparam int unsigned DCACHE_WORD_WIDTH  = 64;
    localparam int unsigned DCACHE_LINE_WIDTH  = 128;
    localparam int unsigned DCACHE_NUM_WAYS    = 2;
    localparam int unsigned DCACHE_NUM_SETS    = 16;
    localparam int unsigned DCACHE_BYTE_OFFSET = 4;
    // set bits plus byte offset
    localparam int unsigned DCACHE_INDEX_WIDTH = 8;
    localparam int unsigned DCACHE_TAG_WIDTH   = 24;
    // derived: set field and byte offset of a word inside a line
    localparam int unsigned DCACHE_SET_WIDTH   = DCACHE_INDEX_WIDTH - DCACHE_BYTE_OFFSET;
    localparam int unsigned DCACHE_WORD_OFFSET = $clog2(DCACHE_WORD_WIDTH / 8);

    typedef logic [DCACHE_NUM_WAYS-1:0] way_mask_t;

    // ------------------------------
    // core port
    // ------------------------------
    typedef struct packed {
        logic                            data_req;
        logic [DCACHE_INDEX_WIDTH-1:0]   address_index;
        logic                            data_we;
        logic [DCACHE_WORD_WIDTH/8-1:0]  data_be;
        logic [DCACHE_WORD_WIDTH-1:0]    data_wdata;
        // tag arrives one cycle after the index
        logic                            tag_valid;
        logic [DCACHE_TAG_WIDTH-1:0]     address_tag;
    } dcache_req_t;

    typedef struct packed {
        logic                            data_gnt;
        logic                            data_rvalid;
        logic [DCACHE_WORD_WIDTH-1:0]    data_rdata;
    } dcache_rsp_t;

    // ------------------------------
    // array port
    // ------------------------------
    typedef struct packed {
        way_mask_t                       way_req;
        logic                            we;
        logic [DCACHE_INDEX_WIDTH-1:0]   index;
        logic [DCACHE_TAG_WIDTH-1:0]     tag;
        logic [DCACHE_LINE_WIDTH-1:0]    wdata;
        logic [DCACHE_LINE_WIDTH/8-1:0]  be;
        logic                            set_dirty;
        logic                            set_valid;
    } array_req_t;

    typedef struct packed {
        way_mask_t                       hit_way;
        logic [DCACHE_LINE_WIDTH-1:0]    rdata;
        // way the next refill goes to, one-hot
        way_mask_t                       victim_way;
        logic [DCACHE_LINE_WIDTH-1:0]    victim_line;
        logic [DCACHE_TAG_WIDTH-1:0]     victim_tag;
        logic                            victim_dirty;
        logic                            victim_valid;
    } array_rsp_t;

    // ------------------------------
    // miss unit and memory port
    // ------------------------------
    typedef struct packed {
        logic                            valid;
        logic                            bypass;
        logic [DCACHE_ADDR_WIDTH-1:0]    addr;
        logic                            we;
        logic [DCACHE_WORD_WIDTH/8-1:0]  be;
        logic [DCACHE_WORD_WIDTH-1:0]    wdata;
    } miss_req_t;

    typedef struct packed {
        logic                            done;
        logic [DCACHE_WORD_WIDTH-1:0]    rdata;
    } miss_rsp_t;

    typedef struct packed {
        logic                            valid;
        logic                            we;
        logic                            bypass;
        logic [DCACHE_ADDR_WIDTH-1:0]    addr;
        logic [DCACHE_LINE_WIDTH/8-1:0]  be;
        logic [DCACHE_LINE_WIDTH-1:0]    wdata;
    } mem_req_t;

    typedef struct packed {
        logic                            ack;
        logic [DCACHE_LINE_WIDTH-1:0]    rdata;
    } mem_rsp_t;

endpackage

//--- src/dcache_top.sv
/*
 * dcache top
 * two-way data cache for one load/store port; controller, array and
 * miss unit wired together
 */
`timescale 1ns/1ns

module dcache_top #(
    parameter logic [dcache_pkg::DCACHE_ADDR_WIDTH-1:0] CACHEABLE_BASE = 32'h0000_1000
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  dcache_pkg::dcache_req_t req_i,
    output dcache_pkg::dcache_rsp_t rsp_o,
    output dcache_pkg::mem_req_t    mem_req_o,
    input  dcache_pkg::mem_rsp_t    mem_rsp_i,
    output logic                    busy_o
);

    // controller and refill both write the array
    dcache_pkg::array_req_t ctrl_array_req;
    dcache_pkg::array_req_t refill_req;
    dcache_pkg::array_rsp_t array_rsp;
    dcache_pkg::miss_req_t  miss_req;
    dcache_pkg::miss_rsp_t  miss_rsp;

    dcache_ctrl #(
        .CACHEABLE_BASE(CACHEABLE_BASE)
    ) u_ctrl (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .req_i      (req_i),
        .rsp_o      (rsp_o),
        .array_req_o(ctrl_array_req),
        .array_rsp_i(array_rsp),
        .miss_req_o (miss_req),
        .miss_rsp_i (miss_rsp),
        .busy_o     (busy_o)
    );

    dcache_array u_array (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ctrl_req_i  (ctrl_array_req),
        .refill_req_i(refill_req),
        .rsp_o       (array_rsp)
    );

    // miss unit also watches the array for the victim
    dcache_miss_unit u_miss (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .miss_req_i  (miss_req),
        .miss_rsp_o  (miss_rsp),
        .array_rsp_i (array_rsp),
        .refill_req_o(refill_req),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i)
    );

endmodule

//--- verification/dcache_tb.sv
/*
 * dcache testbench
 * runs a table of loads and stores through the cache, answers the memory
 * port with a random latency and checks data, timing and memory traffic
 */
`timescale 1ns/1ns

module dcache_tb;

    localparam logic [31:0] CACHEABLE_BASE = 32'h0000_1000;
    localparam int          NUM_ROWS       = 17;

    typedef struct {
        string       name;
        bit          we;
        logic [31:0] addr;
        logic [7:0]  be;
        logic [63:0] wdata;
        // issued in the hit cycle of the row before
        bit          chain;
        // expected hit with fixed timing
        bit          hit;
        int          reads;
    } row_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    dcache_pkg::dcache_req_t req;
    dcache_pkg::dcache_rsp_t rsp;
    dcache_pkg::mem_req_t    mem_req;
    dcache_pkg::mem_rsp_t    mem_rsp = '0;
    logic                    busy;

    row_t       rows [NUM_ROWS];
    int         n_rows = 0;
    int         reads_at [NUM_ROWS];
    int         byp_at [NUM_ROWS];
    int         reads = 0;
    int         bypasses = 0;
    int         errors = 0;
    int         seed = 32'h64a9a5c6;
    // memory contents and the bytes the core expects
    logic [7:0] mem [logic [31:0]];
    logic [7:0] ref_mem [logic [31:0]];
    bit         mem_busy = 1'b0;
    int         mem_wait = 0;

    dcache_top #(
        .CACHEABLE_BASE(CACHEABLE_BASE)
    ) u_dut (
        .clk_i    (clk),
        .rst_ni   (rst_n),
        .req_i    (req),
        .rsp_o    (rsp),
        .mem_req_o(mem_req),
        .mem_rsp_i(mem_rsp),
        .busy_o   (busy)
    );

    always #4 clk = ~clk;

    // ------------------------------
    // memory model
    // ------------------------------
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ {a[3:0], a[7:4]} ^ 8'h5a;
    endfunction

    function automatic logic [7:0] mem_byte(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_byte(a);
    endfunction

    function automatic logic [7:0] expected_byte(input logic [31:0] a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return fill_byte(a);
    endfunction

    function automatic logic [63:0] expected_word(input logic [31:0] addr);
        logic [63:0] word;
        for (int b = 0; b < 8; b++) begin
            word[b*8 +: 8] = expected_byte({addr[31:3], 3'b000} + 32'(b));
        end
        return word;
    endfunction

    // one line-wide transaction with byte-masked writes
    task automatic serve_mem;
        logic [31:0]  base;
        logic [127:0] line;
        base = {mem_req.addr[31:4], 4'h0};
        for (int b = 0; b < 16; b++) begin
            if (mem_req.we && mem_req.be[b]) begin
                mem[base + 32'(b)] = mem_req.wdata[b*8 +: 8];
            end
            line[b*8 +: 8] = mem_byte(base + 32'(b));
        end
        if (!mem_req.we) begin
            reads++;
        end
        if (mem_req.bypass) begin
            bypasses++;
        end
        mem_rsp.rdata <= line;
        mem_rsp.ack   <= 1'b1;
    endtask

    // ack after a random wait of 1 to 4 cycles
    always @(posedge clk) begin
        mem_rsp.ack <= 1'b0;
        if (rst_n && mem_req.valid && !mem_rsp.ack) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = $unsigned($random(seed)) % 4;
            end
            if (mem_wait == 0) begin
                serve_mem();
                mem_busy = 1'b0;
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    task automatic check_value(input string name, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
        value_ok: assert (exp === act)
            else begin
                errors++;
                $display("FAIL %s %s: expected %h actual %h", name, what, exp, act);
            end
    endtask

    // memory traffic of one row
    // bypass only below the cacheable base
    task automatic check_counts(input int i);
        check_value(rows[i].name, "memory reads", rows[i].reads, reads - reads_at[i]);
        check_value(rows[i].name, "bypass accesses", rows[i].addr < CACHEABLE_BASE,
                    bypasses - byp_at[i]);
    endtask

    task automatic check_memory;
        foreach (ref_mem[a]) begin
            check_value("memory", $sformatf("byte %h", a), ref_mem[a], mem_byte(a));
        end
    endtask

    // ------------------------------
    // core port
    // ------------------------------
    task automatic record_store(input int i);
        for (int b = 0; b < 8; b++) begin
            if (rows[i].be[b]) begin
                ref_mem[{rows[i].addr[31:3], 3'b000} + 32'(b)] = rows[i].wdata[b*8 +: 8];
            end
        end
    endtask

    // request fields of a row driven at the current rising edge
    task automatic drive_req(input int i);
        req.data_req      <= 1'b1;
        req.data_we       <= rows[i].we;
        req.address_index <= rows[i].addr[7:0];
        req.data_be       <= rows[i].be;
        req.data_wdata    <= rows[i].wdata;
        req.tag_valid     <= 1'b0;
        reads_at[i] = reads;
        byp_at[i]   = bypasses;
    endtask

    task automatic finish_load(input int i, input bit granted, input bit chain_next);
        int lat;
        if (!granted) begin
            @(negedge clk);
            while (!rsp.data_gnt) begin
                @(posedge clk);
                @(negedge clk);
            end
        end
        // tag cycle also carries a chained load request
        @(posedge clk);
        if (chain_next) begin
            drive_req(i + 1);
        end else begin
            req.data_req <= 1'b0;
        end
        req.tag_valid   <= 1'b1;
        req.address_tag <= rows[i].addr[31:8];
        lat = 1;
        @(negedge clk);
        while (!rsp.data_rvalid) begin
            @(posedge clk);
            req.tag_valid <= 1'b0;
            @(negedge clk);
            lat++;
        end
        check_value(rows[i].name, "load data", expected_word(rows[i].addr), rsp.data_rdata);
        check_value(rows[i].name, "busy while active", 1, busy);
        if (rows[i].hit) begin
            check_value(rows[i].name, "grant to rvalid cycles", 1, lat);
        end
        check_counts(i);
        if (chain_next) begin
            check_value(rows[i + 1].name, "grant in hit cycle", 1, rsp.data_gnt);
        end
    endtask

    task automatic finish_store(input int i);
        int lat;
        lat = 0;
        @(negedge clk);
        while (!rsp.data_gnt) begin
            // tag held from the cycle after the request until the grant
            @(posedge clk);
            req.tag_valid   <= 1'b1;
            req.address_tag <= rows[i].addr[31:8];
            @(negedge clk);
            lat++;
        end
        record_store(i);
        check_value(rows[i].name, "busy while active", 1, busy);
        if (rows[i].hit) begin
            check_value(rows[i].name, "request to grant cycles", 2, lat);
        end
        check_counts(i);
    endtask

    // ------------------------------
    // access table
    // ------------------------------
    task automatic add_row(input string name, input bit we, input logic [31:0] addr,
                           input logic [7:0] be, input logic [63:0] wdata,
                           input bit chain, input bit hit, input int rd);
        rows[n_rows].name  = name;
        rows[n_rows].we    = we;
        rows[n_rows].addr  = addr;
        rows[n_rows].be    = be;
        rows[n_rows].wdata = wdata;
        rows[n_rows].chain = chain;
        rows[n_rows].hit   = hit;
        rows[n_rows].reads = rd;
        n_rows++;
    endtask

    task automatic build_table;
        // set 3 holds lines 0x2030, 0x3030, 0x4030, 0x5030
        add_row("ld_miss_a",        0, 32'h0000_2030, 8'hff, 64'h0, 0, 0, 1);
        add_row("ld_hit_a_word1",   0, 32'h0000_2038, 8'hff, 64'h0, 0, 1, 0);
        add_row("st_hit_a",         1, 32'h0000_2030, 8'h0f, 64'hdead_beef_cafe_f00d, 0, 1, 0);
        add_row("ld_hit_a_merged",  0, 32'h0000_2030, 8'hff, 64'h0, 0, 1, 0);
        add_row("ld_miss_e",        0, 32'h0000_2040, 8'hff, 64'h0, 0, 0, 1);
        add_row("ld_b2b_first",     0, 32'h0000_2038, 8'hff, 64'h0, 0, 1, 0);
        add_row("ld_b2b_second",    0, 32'h0000_2048, 8'hff, 64'h0, 1, 1, 0);
        add_row("ld_miss_b",        0, 32'h0000_3038, 8'hff, 64'h0, 0, 0, 1);
        add_row("ld_miss_c_evict",  0, 32'h0000_4030, 8'hff, 64'h0, 0, 0, 1);
        add_row("ld_miss_d",        0, 32'h0000_5038, 8'hff, 64'h0, 0, 0, 1);
        add_row("ld_a_after_evict", 0, 32'h0000_2030, 8'hff, 64'h0, 0, 0, 1);
        // uncacheable region
        add_row("bypass_ld",        0, 32'h0000_0108, 8'hff, 64'h0, 0, 0, 1);
        add_row("bypass_st",        1, 32'h0000_0108, 8'hf0, 64'h0123_4567_89ab_cdef, 0, 0, 0);
        add_row("bypass_ld_again",  0, 32'h0000_0108, 8'hff, 64'h0, 0, 0, 1);
        add_row("bypass_ld_word0",  0, 32'h0000_0100, 8'hff, 64'h0, 0, 0, 1);
        // no-allocate store followed by a load that must miss
        add_row("st_miss",          1, 32'h0000_6070, 8'hff, 64'hfeed_face_5a5a_a5a5, 0, 0, 0);
        add_row("ld_after_st_miss", 0, 32'h0000_6070, 8'hff, 64'h0, 0, 0, 1);
    endtask

    initial begin
        bit chain_next;
        req   = '0;
        rst_n = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("reset", "idle outputs", 64'd0,
                    {rsp.data_gnt, rsp.data_rvalid, mem_req.valid, busy});
        @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            chain_next = (i + 1 < NUM_ROWS) && rows[i + 1].chain;
            if (rows[i].chain) begin
                finish_load(i, 1'b1, chain_next);
            end else begin
                @(posedge clk);
                drive_req(i);
                if (rows[i].we) begin
                    finish_store(i);
                end else begin
                    finish_load(i, 1'b0, chain_next);
                end
            end
        end
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        // controller back in idle after the last row
        check_value("end", "busy when idle", 0, busy);
        // every store must have reached memory by now
        check_memory();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog allows 60 cycles per row plus reset
    initial begin
        repeat (60 * NUM_ROWS + 10) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", 60 * NUM_ROWS + 10);
        $display("TEST FAIL");
        $finish;
    end

endmodule
